// File: all.f
+incdir+tests
src/sensor_pkg.sv
src/csi2_pkg.sv
src/csi2_packet_ctrl.sv
src/csi2_header_ecc.sv
src/csi2_payload_crc.sv
src/csi2_lane_sequencer.sv
src/csi2_tx_byte_top.sv
tests/tb_csi2_tx_byte.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f all.f --top-module tb_csi2_tx_byte \
    || { echo "build failed"; exit 1; }

sim_output="$(./obj_dir/Vtb_csi2_tx_byte)"
echo "$sim_output"

echo "$sim_output" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1

// File: tests/csi2_ref_model.svh
`ifndef CSI2_REF_MODEL_SVH
`define CSI2_REF_MODEL_SVH

// next state of the payload generator
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// one line of random payload bytes
function automatic void make_payload();
    payload_q.delete();
    for (int i = 0; i < LINE_BYTES; i++) begin
        lcg_state = lcg_next(lcg_state);
        payload_q.push_back(lcg_state[31:24]);  // upper bits are the most random
    end
endfunction

// csi-2 hamming code, d[7:0] is the data id
function automatic logic [5:0] ecc_of_header(input logic [23:0] d);
    logic [5:0] p;
    p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13] ^ d[16]
         ^ d[20] ^ d[21] ^ d[22] ^ d[23];
    p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14] ^ d[17]
         ^ d[20] ^ d[21] ^ d[22] ^ d[23];
    p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15] ^ d[18]
         ^ d[20] ^ d[21] ^ d[22];
    p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15] ^ d[19]
         ^ d[20] ^ d[21] ^ d[23];
    p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18] ^ d[19]
         ^ d[20] ^ d[22] ^ d[23];
    p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[18]
         ^ d[19] ^ d[21] ^ d[22] ^ d[23];
    return p;
endfunction

// x^16 + x^12 + x^5 + 1, bit serial, lsb of each byte first
function automatic logic [15:0] crc_of_bytes(input logic [7:0] data [$]);
    logic [15:0] crc;
    logic        fb;
    crc = 16'hFFFF;
    foreach (data[n]) begin
        for (int b = 0; b < 8; b++) begin
            fb  = crc[0] ^ data[n][b];
            crc = crc >> 1;
            if (fb) begin
                crc[15] = ~crc[15];  // x^0 tap
                crc[10] = ~crc[10];  // x^5 tap
                crc[3]  = ~crc[3];   // x^12 tap
            end
        end
    end
    return crc;
endfunction

function automatic void push_header(input logic [7:0] data_id, input logic [15:0] field);
    expect_q.push_back(data_id);
    expect_q.push_back(field[7:0]);
    expect_q.push_back(field[15:8]);
    expect_q.push_back({2'b00, ecc_of_header({field, data_id})});
endfunction

function automatic void expect_short(input logic [7:0] data_id, input logic [15:0] frame);
    expect_q.delete();
    push_header(data_id, frame);
endfunction

function automatic void expect_long();
    logic [15:0] crc;
    expect_q.delete();
    push_header(8'h2B, 16'(LINE_BYTES));  // raw10 on channel 0
    foreach (payload_q[i]) begin
        expect_q.push_back(payload_q[i]);
    end
    crc = crc_of_bytes(payload_q);
    expect_q.push_back(crc[7:0]);
    expect_q.push_back(crc[15:8]);
endfunction

`endif

// File: tests/tb_csi2_tx_byte.sv
`timescale 1ns/1ps

module tb_csi2_tx_byte;

    localparam int LINE_BYTES     = 20;  // 16 raw10 pixels
    localparam int PAYLOAD_DELAY  = 5;
    localparam int START_TIMEOUT  = 16;
    localparam int PACKET_TIMEOUT = 40;
    localparam int IDLE_TIMEOUT   = 64;
    localparam int NUM_STEPS      = 10;

    localparam int K_FRAME_START = 0;
    localparam int K_LINE        = 1;
    localparam int K_FRAME_END   = 2;
    localparam int K_RESET_START = 3;

    logic        clock_camera_byte = 1'b0;
    logic        reset_camera_byte_n;
    logic        fv_start;
    logic        fv_end;
    logic        lv_start;
    logic        lv_end;
    logic        byte_en;
    logic [7:0]  byte_data;
    logic [7:0]  lane_byte;
    logic        lane_valid;
    logic        packet_start;
    logic        packet_end;

    // two frames of two lines, then a frame right after a reset
    int step_kind [NUM_STEPS] = '{K_FRAME_START, K_LINE, K_LINE, K_FRAME_END,
                                  K_FRAME_START, K_LINE, K_LINE, K_FRAME_END,
                                  K_RESET_START, K_FRAME_END};
    int step_gap  [NUM_STEPS] = '{10, 10, 8, 10, 8, 8, 8, 12, 8, 10};

    int          cycle_cnt = 0;
    logic [31:0] lcg_state = 32'ha6cb_26ac;
    logic [15:0] frame_model = 16'd0;  // expected frame number
    logic [7:0]  payload_q [$];
    logic [7:0]  expect_q [$];
    logic [7:0]  got_q [$];
    bit          drive_done;
    int          test_errs;
    int          tests_run;
    int          tests_failed;
    int          start_cyc;
    int          end_cyc;

    `include "csi2_ref_model.svh"

    always #2 clock_camera_byte = ~clock_camera_byte;

    always @(posedge clock_camera_byte) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    csi2_tx_byte_top u_csi2_tx_byte_top (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .fv_start_i          (fv_start),
        .fv_end_i            (fv_end),
        .lv_start_i          (lv_start),
        .lv_end_i            (lv_end),
        .byte_en_i           (byte_en),
        .byte_data_i         (byte_data),
        .lane_byte_o         (lane_byte),
        .lane_valid_o        (lane_valid),
        .packet_start_o      (packet_start),
        .packet_end_o        (packet_end)
    );

    function automatic string kind_name(input int kind);
        case (kind)
            K_FRAME_START: return "frame start";
            K_LINE:        return "line";
            K_FRAME_END:   return "frame end";
            default:       return "frame start after reset";
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clock_camera_byte);
        #1;
    endtask

    task automatic report_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        test_errs++;
    endtask

    task automatic check_idle();
        assert (!lane_valid && !packet_start && !packet_end)
        else report_error($sformatf("lane not idle, valid %b start %b end %b",
                                    lane_valid, packet_start, packet_end));
    endtask

    task automatic apply_reset();
        reset_camera_byte_n = 1'b0;
        repeat (2) begin
            @(negedge clock_camera_byte);
            check_idle();
            next_cycle();
        end
        reset_camera_byte_n = 1'b1;
    endtask

    task automatic drive_step(input int kind, input int gap);
        if (kind == K_LINE) begin
            lv_start  = 1'b1;
            byte_en   = 1'b1;  // first byte with lv_start
            byte_data = payload_q[0];
            for (int i = 1; i < LINE_BYTES; i++) begin
                next_cycle();
                lv_start  = 1'b0;
                byte_data = payload_q[i];
            end
            next_cycle();
            byte_en   = 1'b0;
            byte_data = 8'h00;
            lv_end    = 1'b1;  // cycle after the last byte
        end
        else if (kind == K_FRAME_END) begin
            fv_end = 1'b1;
        end
        else begin
            fv_start = 1'b1;
        end
        next_cycle();
        fv_start = 1'b0;
        fv_end   = 1'b0;
        lv_end   = 1'b0;
        repeat (gap - 1) next_cycle();
        drive_done = 1'b1;
    endtask

    task automatic capture_packet(output int first_cyc, output int last_cyc);
        int waited;
        bit done;
        got_q.delete();
        first_cyc = -1;
        last_cyc  = -1;
        waited    = 0;
        done      = 1'b0;
        @(negedge clock_camera_byte);
        while (!packet_start && waited < START_TIMEOUT) begin
            check_idle();
            waited++;
            @(negedge clock_camera_byte);
        end
        if (!packet_start) begin
            $display("timeout at %0d ns: no packet started within %0d cycles",
                     $time, START_TIMEOUT);
            test_errs++;
        end
        else begin
            first_cyc = cycle_cnt;
            waited    = 0;
            while (!done && waited < PACKET_TIMEOUT) begin
                assert (lane_valid) else report_error("lane_valid dropped inside a packet");
                assert (got_q.size() == 0 || !packet_start)
                else report_error("packet_start repeated inside a packet");
                got_q.push_back(lane_byte);
                if (packet_end) begin
                    done     = 1'b1;
                    last_cyc = cycle_cnt;
                end
                else begin
                    waited++;
                    @(negedge clock_camera_byte);
                end
            end
            if (!done) begin
                $display("timeout at %0d ns: packet did not end within %0d cycles",
                         $time, PACKET_TIMEOUT);
                test_errs++;
            end
        end
    endtask

    // lane stays quiet until the stimulus gap is over
    task automatic watch_idle();
        int waited;
        waited = 0;
        while (!drive_done && waited < IDLE_TIMEOUT) begin
            @(negedge clock_camera_byte);
            check_idle();
            waited++;
        end
        if (!drive_done) begin
            $display("timeout at %0d ns: stimulus did not finish within %0d cycles",
                     $time, IDLE_TIMEOUT);
            test_errs++;
        end
    endtask

    task automatic check_packet(input int t, input int last_expected);
        int n;
        assert (start_cyc == t + 1)
        else report_error($sformatf("packet started in cycle %0d, expected %0d",
                                    start_cyc, t + 1));
        assert (end_cyc == last_expected)
        else report_error($sformatf("packet ended in cycle %0d, expected %0d",
                                    end_cyc, last_expected));
        assert (got_q.size() == expect_q.size())
        else report_error($sformatf("packet has %0d bytes, expected %0d",
                                    got_q.size(), expect_q.size()));
        n = (got_q.size() < expect_q.size()) ? got_q.size() : expect_q.size();
        for (int i = 0; i < n; i++) begin
            assert (got_q[i] == expect_q[i])
            else report_error($sformatf("byte %0d is %h, expected %h",
                                        i, got_q[i], expect_q[i]));
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end
        else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, test_errs);
        end
    endtask

    initial begin
        int t;
        int last_expected;
        reset_camera_byte_n = 1'b0;
        fv_start     = 1'b0;
        fv_end       = 1'b0;
        lv_start     = 1'b0;
        lv_end       = 1'b0;
        byte_en      = 1'b0;
        byte_data    = 8'h00;
        drive_done   = 1'b0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;

        apply_reset();
        repeat (3) next_cycle();

        // catalogue check value of this crc over "123456789"
        payload_q.delete();
        for (int c = 0; c < 9; c++) begin
            payload_q.push_back(8'h31 + 8'(c));
        end
        assert (crc_of_bytes(payload_q) == 16'h6F91)
        else report_error("reference crc disagrees with the check value 6f91");
        finish_test("reference crc");

        foreach (step_kind[s]) begin
            test_errs  = 0;
            drive_done = 1'b0;
            next_cycle();
            if (step_kind[s] == K_RESET_START) begin
                apply_reset();
                frame_model = 16'd0;
                repeat (3) next_cycle();
            end
            t = cycle_cnt;
            if (step_kind[s] == K_LINE) begin
                make_payload();
                expect_long();
                last_expected = t + LINE_BYTES + PAYLOAD_DELAY + 1;  // crc high byte
            end
            else if (step_kind[s] == K_FRAME_END) begin
                expect_short(8'h01, frame_model);
                last_expected = t + 4;
            end
            else begin
                expect_short(8'h00, frame_model);
                last_expected = t + 4;
            end
            fork
                drive_step(step_kind[s], step_gap[s]);
                begin
                    capture_packet(start_cyc, end_cyc);
                    watch_idle();
                end
            join
            if (step_kind[s] == K_FRAME_END) begin
                frame_model++;  // next frame counts up
            end
            check_packet(t, last_expected);
            finish_test($sformatf("step %0d %s", s, kind_name(step_kind[s])));
        end

        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end
        else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: src/csi2_tx_byte_top.sv
`timescale 1ns/1ps

module csi2_tx_byte_top (
    input  logic       clock_camera_byte,
    input  logic       reset_camera_byte_n,

    input  logic       fv_start_i,
    input  logic       fv_end_i,
    input  logic       lv_start_i,
    input  logic       lv_end_i,
    input  logic       byte_en_i,
    input  logic [7:0] byte_data_i,

    output logic [7:0] lane_byte_o,
    output logic       lane_valid_o,
    output logic       packet_start_o,
    output logic       packet_end_o
);

    logic                          header_valid;
    logic                          header_long;
    csi2_pkg::csi2_data_id_t       header_data_id;
    csi2_pkg::csi2_header_field_u  header_field;
    logic [5:0]                    header_ecc;

    logic                          crc_clear;
    logic                          crc_byte_en;
    logic [7:0]                    crc_byte;
    logic [15:0]                   crc_value;

    csi2_packet_ctrl u_csi2_packet_ctrl (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .fv_start_i          (fv_start_i),
        .fv_end_i            (fv_end_i),
        .lv_start_i          (lv_start_i),
        .header_valid_o      (header_valid),
        .header_long_o       (header_long),
        .header_data_id_o    (header_data_id),
        .header_field_o      (header_field)
    );

    csi2_header_ecc u_csi2_header_ecc (
        .data_id_i (header_data_id),
        .field_i   (header_field),
        .ecc_o     (header_ecc)
    );

    csi2_payload_crc u_csi2_payload_crc (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .clear_i             (crc_clear),
        .byte_en_i           (crc_byte_en),
        .byte_i              (crc_byte),
        .crc_o               (crc_value)
    );

    csi2_lane_sequencer u_csi2_lane_sequencer (
        .clock_camera_byte   (clock_camera_byte),
        .reset_camera_byte_n (reset_camera_byte_n),
        .header_valid_i      (header_valid),
        .header_long_i       (header_long),
        .header_data_id_i    (header_data_id),
        .header_field_i      (header_field),
        .header_ecc_i        (header_ecc),
        .byte_en_i           (byte_en_i),
        .byte_data_i         (byte_data_i),
        .lv_end_i            (lv_end_i),
        .crc_i               (crc_value),
        .crc_clear_o         (crc_clear),
        .crc_byte_en_o       (crc_byte_en),
        .crc_byte_o          (crc_byte),
        .lane_byte_o         (lane_byte_o),
        .lane_valid_o        (lane_valid_o),
        .packet_start_o      (packet_start_o),
        .packet_end_o        (packet_end_o)
    );

endmodule

// File: src/csi2_lane_sequencer.sv
`timescale 1ns/1ps

module csi2_lane_sequencer (
    input  logic                           clock_camera_byte,
    input  logic                           reset_camera_byte_n,

    input  logic                           header_valid_i,
    input  logic                           header_long_i,
    input  csi2_pkg::csi2_data_id_t        header_data_id_i,
    input  csi2_pkg::csi2_header_field_u   header_field_i,
    input  logic [5:0]                     header_ecc_i,

    input  logic                           byte_en_i,
    input  logic [7:0]                     byte_data_i,
    input  logic                           lv_end_i,

    input  logic [15:0]                    crc_i,
    output logic                           crc_clear_o,
    output logic                           crc_byte_en_o,
    output logic [7:0]                     crc_byte_o,

    output logic [7:0]                     lane_byte_o,
    output logic                           lane_valid_o,
    output logic                           packet_start_o,
    output logic                           packet_end_o
);

    logic [sensor_pkg::PAYLOAD_DELAY-1:0] en_pipe_q;
    logic [sensor_pkg::PAYLOAD_DELAY-1:0] end_pipe_q;
    logic [7:0]  data_pipe_q [sensor_pkg::PAYLOAD_DELAY];

    logic [1:0]  state_q;
    logic [1:0]  idx_q;      // byte index within header or footer
    logic        long_q;
    logic [15:0] field_q;
    logic [5:0]  ecc_q;

    logic        header_start;
    logic        dly_en;
    logic        dly_end;
    logic [7:0]  dly_data;

    assign header_start = (state_q == csi2_pkg::SEQ_IDLE) && header_valid_i;

    assign dly_en   = en_pipe_q[sensor_pkg::PAYLOAD_DELAY-1];
    assign dly_end  = end_pipe_q[sensor_pkg::PAYLOAD_DELAY-1];
    assign dly_data = data_pipe_q[sensor_pkg::PAYLOAD_DELAY-1];

    // payload delay line
    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            en_pipe_q  <= '0;
            end_pipe_q <= '0;
        end
        else begin
            en_pipe_q  <= {en_pipe_q[sensor_pkg::PAYLOAD_DELAY-2:0], byte_en_i};
            end_pipe_q <= {end_pipe_q[sensor_pkg::PAYLOAD_DELAY-2:0], lv_end_i};
        end
    end

    always_ff @(posedge clock_camera_byte) begin
        data_pipe_q[0] <= byte_data_i;
        for (int i = 1; i < sensor_pkg::PAYLOAD_DELAY; i++) begin
            data_pipe_q[i] <= data_pipe_q[i-1];
        end
    end

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            state_q <= csi2_pkg::SEQ_IDLE;
            idx_q   <= 2'd0;
            long_q  <= 1'b0;
        end
        else begin
            case (state_q)
                csi2_pkg::SEQ_IDLE: begin
                    if (header_valid_i) begin
                        state_q <= csi2_pkg::SEQ_HEADER;
                        idx_q   <= 2'd1;  // data id already out
                        long_q  <= header_long_i;
                    end
                end
                csi2_pkg::SEQ_HEADER: begin
                    idx_q <= idx_q + 2'd1;
                    if (idx_q == 2'(csi2_pkg::HEADER_BYTES - 1)) begin
                        state_q <= long_q ? csi2_pkg::SEQ_PAYLOAD : csi2_pkg::SEQ_IDLE;
                    end
                end
                csi2_pkg::SEQ_PAYLOAD: begin
                    if (dly_end) begin
                        state_q <= csi2_pkg::SEQ_FOOTER;
                        idx_q   <= 2'd1;  // crc lo goes out now
                    end
                end
                default: begin
                    idx_q <= idx_q + 2'd1;
                    if (idx_q == 2'(csi2_pkg::FOOTER_BYTES - 1)) begin
                        state_q <= csi2_pkg::SEQ_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock_camera_byte) begin
        if (header_start) begin
            field_q <= header_field_i;
            ecc_q   <= header_ecc_i;
        end
    end

    always_comb begin
        lane_byte_o    = 8'h00;
        lane_valid_o   = 1'b0;
        packet_start_o = 1'b0;
        packet_end_o   = 1'b0;
        case (state_q)
            csi2_pkg::SEQ_IDLE: begin
                if (header_valid_i) begin
                    lane_byte_o    = header_data_id_i;
                    lane_valid_o   = 1'b1;
                    packet_start_o = 1'b1;
                end
            end
            csi2_pkg::SEQ_HEADER: begin
                lane_valid_o = 1'b1;
                case (idx_q)
                    2'd1:    lane_byte_o = field_q[7:0];
                    2'd2:    lane_byte_o = field_q[15:8];
                    default: lane_byte_o = {2'b00, ecc_q};
                endcase
                packet_end_o = (idx_q == 2'(csi2_pkg::HEADER_BYTES - 1)) && !long_q;
            end
            csi2_pkg::SEQ_PAYLOAD: begin
                if (dly_end) begin
                    lane_byte_o  = crc_i[7:0];
                    lane_valid_o = 1'b1;
                end
                else if (dly_en) begin
                    lane_byte_o  = dly_data;
                    lane_valid_o = 1'b1;
                end
            end
            default: begin
                lane_byte_o  = crc_i[8*idx_q +: 8];
                lane_valid_o = 1'b1;
                packet_end_o = (idx_q == 2'(csi2_pkg::FOOTER_BYTES - 1));
            end
        endcase
    end

    assign crc_clear_o   = header_start && header_long_i;
    assign crc_byte_en_o = (state_q == csi2_pkg::SEQ_PAYLOAD) && dly_en && !dly_end;
    assign crc_byte_o    = dly_data;

endmodule

// File: src/csi2_payload_crc.sv
`timescale 1ns/1ps

module csi2_payload_crc (
    input  logic        clock_camera_byte,
    input  logic        reset_camera_byte_n,
    input  logic        clear_i,
    input  logic        byte_en_i,
    input  logic [7:0]  byte_i,
    output logic [15:0] crc_o
);

    logic [15:0] crc_q;

    // one byte, lsb first
    function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic [7:0] data);
        logic [15:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ csi2_pkg::CRC_POLY;
            end
            else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            crc_q <= csi2_pkg::CRC_SEED;
        end
        else if (clear_i) begin
            crc_q <= csi2_pkg::CRC_SEED;  // new long packet
        end
        else if (byte_en_i) begin
            crc_q <= crc_step(crc_q, byte_i);
        end
    end

    assign crc_o = crc_q;

endmodule

// File: src/csi2_header_ecc.sv
`timescale 1ns/1ps

module csi2_header_ecc (
    input  csi2_pkg::csi2_data_id_t        data_id_i,
    input  csi2_pkg::csi2_header_field_u   field_i,
    output logic [5:0]                     ecc_o
);

    logic [23:0] header_bits;

    // bits 7:0 data id, 15:8 field lsb, 23:16 field msb
    assign header_bits = {field_i, data_id_i};

    always_comb begin
        for (int i = 0; i < 6; i++) begin
            ecc_o[i] = ^(header_bits & csi2_pkg::ECC_MASK[i]);
        end
    end

endmodule

// File: src/csi2_packet_ctrl.sv
`timescale 1ns/1ps

module csi2_packet_ctrl (
    input  logic                           clock_camera_byte,
    input  logic                           reset_camera_byte_n,

    input  logic                           fv_start_i,
    input  logic                           fv_end_i,
    input  logic                           lv_start_i,

    output logic                           header_valid_o,
    output logic                           header_long_o,
    output csi2_pkg::csi2_data_id_t        header_data_id_o,
    output csi2_pkg::csi2_header_field_u   header_field_o
);

    logic [15:0] frame_count_q;  // number for the next frame start

    always_ff @(posedge clock_camera_byte or negedge reset_camera_byte_n) begin
        if (!reset_camera_byte_n) begin
            header_valid_o <= 1'b0;
            header_long_o  <= 1'b0;
            frame_count_q  <= 16'd0;
        end
        else begin
            header_valid_o <= fv_start_i | fv_end_i | lv_start_i;
            header_long_o  <= lv_start_i & ~(fv_start_i | fv_end_i);
            if (fv_start_i) begin
                frame_count_q <= frame_count_q + 16'd1;
            end
        end
    end

    // header contents, qualified by header_valid_o
    always_ff @(posedge clock_camera_byte) begin
        if (fv_start_i) begin
            header_data_id_o.vc         <= csi2_pkg::VIRTUAL_CHANNEL;
            header_data_id_o.dt         <= csi2_pkg::DT_FRAME_START;
            header_field_o.frame_number <= frame_count_q;
        end
        else if (fv_end_i) begin
            header_data_id_o.vc         <= csi2_pkg::VIRTUAL_CHANNEL;
            header_data_id_o.dt         <= csi2_pkg::DT_FRAME_END;
            header_field_o.frame_number <= frame_count_q - 16'd1;  // same as its frame start
        end
        else if (lv_start_i) begin
            header_data_id_o.vc       <= csi2_pkg::VIRTUAL_CHANNEL;
            header_data_id_o.dt       <= csi2_pkg::DT_RAW10;
            header_field_o.word_count <= sensor_pkg::LINE_WORD_COUNT;
        end
    end

endmodule

// File: src/csi2_pkg.sv
package csi2_pkg;

    localparam logic [5:0] DT_FRAME_START = 6'h00;
    localparam logic [5:0] DT_FRAME_END   = 6'h01;
    localparam logic [5:0] DT_RAW10       = 6'h2B;

    localparam logic [1:0] VIRTUAL_CHANNEL = 2'd0;

    localparam int HEADER_BYTES = 4;  // data id, field lo, field hi, ecc
    localparam int FOOTER_BYTES = 2;  // crc lo, crc hi

    // crc-16 ccitt, reflected form
    localparam logic [15:0] CRC_SEED = 16'hFFFF;
    localparam logic [15:0] CRC_POLY = 16'h8408;

    // hamming parity masks over header bits 23:0, entry n gives ecc bit n
    localparam logic [5:0][23:0] ECC_MASK = {
        24'hEFFC00,
        24'hDF03F0,
        24'hB8E38E,
        24'h749A6D,
        24'hF2555B,
        24'hF12CB7
    };

    // lane sequencer states
    localparam logic [1:0] SEQ_IDLE    = 2'd0;
    localparam logic [1:0] SEQ_HEADER  = 2'd1;
    localparam logic [1:0] SEQ_PAYLOAD = 2'd2;
    localparam logic [1:0] SEQ_FOOTER  = 2'd3;

    typedef union packed {
        logic [15:0] word_count;    // long packets
        logic [15:0] frame_number;  // frame start / end
    } csi2_header_field_u;

    typedef struct packed {
        logic [1:0] vc;
        logic [5:0] dt;
    } csi2_data_id_t;

endpackage

// File: src/sensor_pkg.sv
package sensor_pkg;

    // small test sensor, one line of RAW10 pixels
    localparam int SENSOR_X_SIZE = 16;
    localparam int PIXEL_BITS    = 10;

    // payload bytes per line
    localparam logic [15:0] LINE_WORD_COUNT = 16'(SENSOR_X_SIZE * PIXEL_BITS / 8);

    // header is 4 bytes, so the payload waits one cycle longer than that
    localparam int PAYLOAD_DELAY = 5;

endpackage
